// File: vlog.f
+incdir+include
hw/rv_types_pkg.sv
hw/rv_decode.sv
hw/rv_reg_file.sv
hw/rv_execute.sv
hw/rv_exec_core.sv
test/rv_core_props.sv
test/rv_core_checker.sv
test/tb_rv_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the RV32I datapath testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_rv_exec_core -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log || [ "$status" -ne 0 ]; then
  echo "run_sim: FAIL"
  exit 1
fi

echo "run_sim: PASS"
exit 0

// File: test/tb_rv_exec_core.sv
// Testbench top for the RV32I datapath: clock, reset, seeded random
// instruction stream and watchdog; the checker scores every retirement
`timescale 1ns/10ps
`include "rv_core_params.svh"

module tb_rv_exec_core;

  localparam int NUM_TESTS   = 40;
  localparam int TEST_LEN    = 50;
  localparam int CLK_PERIOD  = 4;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_LEN * 2 * CLK_PERIOD * 2;

  logic                  clk;
  logic                  reset_i;
  logic                  instr_valid_i;
  rv_types_pkg::word_t   instr_i;
  rv_types_pkg::word_t   pc_i;
  logic                  retire_valid_o;
  rv_types_pkg::word_t   retire_pc_o;
  rv_types_pkg::regidx_t retire_rd_o;
  logic                  retire_wen_o;
  rv_types_pkg::word_t   retire_data_o;
  logic                  redirect_o;
  rv_types_pkg::word_t   redirect_target_o;
  logic                  mem_ren_o;
  logic                  mem_wen_o;
  rv_types_pkg::word_t   mem_addr_o;
  logic [`RV_NBYTES-1:0] mem_byte_en_o;
  rv_types_pkg::word_t   mem_wdata_o;

  logic                  done;
  int                    error_count;
  integer                seed;
  logic [31:0]           rnd;
  rv_types_pkg::word_t   word;
  rv_types_pkg::word_t   next_pc;
  int                    issued;

  rv_exec_core rv_exec_core_inst (.*);

  rv_core_checker #(.NUM_TESTS(NUM_TESTS), .TEST_LEN(TEST_LEN)) rv_core_checker_inst (
    .clk, .reset_i, .instr_valid_i, .instr_i, .pc_i,
    .retire_valid_i(retire_valid_o), .retire_pc_i(retire_pc_o), .retire_rd_i(retire_rd_o),
    .retire_wen_i(retire_wen_o), .retire_data_i(retire_data_o), .redirect_i(redirect_o),
    .redirect_target_i(redirect_target_o), .mem_ren_i(mem_ren_o), .mem_wen_i(mem_wen_o),
    .mem_addr_i(mem_addr_o), .mem_byte_en_i(mem_byte_en_o), .mem_wdata_i(mem_wdata_o),
    .done_o(done), .error_count_o(error_count)
  );

  bind rv_exec_core rv_core_props rv_core_props_inst (
    .clk(clk), .reset_i(reset_i), .instr_valid_i(instr_valid_i),
    .retire_valid_i(retire_valid_o), .retire_wen_i(retire_wen_o), .redirect_i(redirect_o),
    .mem_ren_i(mem_ren_o), .mem_wen_i(mem_wen_o)
  );

  // Mostly x0 to x3 so that back-to-back dependences are common
  function automatic rv_types_pkg::regidx_t pick_reg();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] < 4'd12)
      return {3'b000, r[5:4]};
    return r[8:4];
  endfunction

  task automatic make_instr(output rv_types_pkg::word_t ins);
    logic [31:0]           sel;
    logic [31:0]           bits;
    logic [2:0]            f3;
    logic                  alt;
    rv_types_pkg::regidx_t rd, rs1, rs2;
    sel  = $random(seed);
    bits = $random(seed);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = bits[14:12];
    alt  = bits[30] && (f3 == 3'b000 || f3 == 3'b101);
    case (sel[3:0])
      4'd0, 4'd1, 4'd2: ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      4'd3, 4'd4, 4'd5: begin
        // Shifts keep the upper immediate bits legal
        if (f3 == 3'b001)
          bits[31:25] = 7'b0;
        else if (f3 == 3'b101)
          bits[31:25] = {1'b0, bits[30], 5'b0};
        ins = {bits[31:20], rs1, f3, rd, 7'b0010011};
      end
      4'd6: ins = {bits[31:12], rd, 7'b0110111};
      4'd7: ins = {bits[31:12], rd, 7'b0010111};
      4'd8: ins = {bits[31:12], rd, 7'b1101111};
      4'd9: ins = {bits[31:20], rs1, 3'b000, rd, 7'b1100111};
      4'd10, 4'd11: begin
        if (f3[2:1] == 2'b01)
          f3[1] = 1'b0;
        ins = {bits[31:25], rs2, rs1, f3, bits[11:7], 7'b1100011};
      end
      4'd12: begin
        if (f3 == 3'b011)
          f3 = 3'b010;
        else if (f3[2:1] == 2'b11)
          f3[1] = 1'b0;
        ins = {bits[31:20], rs1, f3, rd, 7'b0000011};
      end
      4'd13, 4'd14: begin
        f3[2] = 1'b0;
        if (f3[1:0] == 2'b11)
          f3[0] = 1'b0;
        ins = {bits[31:25], rs2, rs1, f3, bits[11:7], 7'b0100011};
      end
      // Opcode outside the kept set, retires as a no-op
      default: ins = {bits[31:7], 7'b0001111};
    endcase
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    seed          = 32'h454c_c53f;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    next_pc       = '0;
    issued        = 0;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    while (issued < NUM_TESTS * TEST_LEN) begin
      @(posedge clk);
      rnd = $random(seed);
      if (rnd[1:0] != 2'b00) begin
        make_instr(word);
        instr_valid_i <= 1'b1;
        instr_i       <= word;
        pc_i          <= next_pc;
        next_pc = next_pc + 32'd4;
        issued++;
      end else begin
        // Idle slot carries junk that must not retire as anything
        instr_valid_i <= 1'b0;
        instr_i       <= {rnd[31:2], 2'b11};
      end
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;
    while (!done)
      @(posedge clk);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: test/rv_core_checker.sv
// Scoreboard for the datapath: an architectural register model predicts the
// retire record of each valid instruction and compares it when the DUT retires
`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_core_checker #(
  parameter int NUM_TESTS = 40,
  parameter int TEST_LEN  = 50
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  rv_types_pkg::word_t   instr_i,
  input  rv_types_pkg::word_t   pc_i,
  input  logic                  retire_valid_i,
  input  rv_types_pkg::word_t   retire_pc_i,
  input  rv_types_pkg::regidx_t retire_rd_i,
  input  logic                  retire_wen_i,
  input  rv_types_pkg::word_t   retire_data_i,
  input  logic                  redirect_i,
  input  rv_types_pkg::word_t   redirect_target_i,
  input  logic                  mem_ren_i,
  input  logic                  mem_wen_i,
  input  rv_types_pkg::word_t   mem_addr_i,
  input  logic [`RV_NBYTES-1:0] mem_byte_en_i,
  input  rv_types_pkg::word_t   mem_wdata_i,
  output logic                  done_o,
  output int                    error_count_o
);

  typedef struct packed {
    rv_types_pkg::word_t   pc;
    rv_types_pkg::regidx_t rd;
    logic                  wen;
    rv_types_pkg::word_t   data;
    logic                  redirect;
    rv_types_pkg::word_t   target;
    logic                  ren;
    logic                  store;
    rv_types_pkg::word_t   addr;
    logic [`RV_NBYTES-1:0] byte_en;
    rv_types_pkg::word_t   wdata;
  } retire_rec_t;

  rv_types_pkg::word_t arch_regs [`RV_NREGS];
  retire_rec_t         pending [$];
  retire_rec_t         head;
  int                  test_idx = 0;
  int                  test_count = 0;
  int                  test_errors = 0;
  int                  tests_failed = 0;
  int                  total_errors = 0;
  string               test_name = "test_00";
  logic                finished = 1'b0;

  assign done_o        = finished;
  assign error_count_o = total_errors;

  // OP and OP-IMM results; alt selects SUB or SRA
  function automatic rv_types_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                                  rv_types_pkg::word_t x,
                                                  rv_types_pkg::word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101:  return alt ? rv_types_pkg::word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, rv_types_pkg::word_t x,
                                      rv_types_pkg::word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  // Executes one instruction on the model in program order
  task automatic predict(rv_types_pkg::word_t ins, rv_types_pkg::word_t pc);
    retire_rec_t           r;
    rv_types_pkg::word_t   a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]            f3;
    logic [`RV_NBYTES-1:0] lanes;
    f3    = ins[14:12];
    a     = arch_regs[ins[19:15]];
    b     = arch_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    r     = '0;
    r.pc  = pc;
    r.rd  = ins[11:7];
    case (f3[1:0])
      2'b00:   lanes = 4'b0001;
      2'b01:   lanes = 4'b0011;
      default: lanes = 4'b1111;
    endcase
    case (ins[6:0])
      7'b0110011: begin
        r.wen  = 1'b1;
        r.data = alu_ref(f3, ins[30], a, b);
      end
      7'b0010011: begin
        r.wen  = 1'b1;
        r.data = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
      end
      7'b0110111: begin
        r.wen  = 1'b1;
        r.data = imm_u;
      end
      7'b0010111: begin
        r.wen  = 1'b1;
        r.data = pc + imm_u;
      end
      7'b1101111, 7'b1100111: begin
        r.wen      = 1'b1;
        r.data     = pc + 32'd4;
        r.redirect = 1'b1;
        r.target   = ins[3] ? pc + imm_j : (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        r.redirect = branch_ref(f3, a, b);
        r.target   = pc + imm_b;
      end
      7'b0000011: begin
        r.ren     = 1'b1;
        r.addr    = a + imm_i;
        r.byte_en = lanes << r.addr[1:0];
      end
      7'b0100011: begin
        r.store   = 1'b1;
        r.addr    = a + imm_s;
        r.byte_en = lanes << r.addr[1:0];
        case (f3[1:0])
          2'b00:   r.wdata = {4{b[7:0]}};
          2'b01:   r.wdata = {2{b[15:0]}};
          default: r.wdata = b;
        endcase
      end
      default: ;
    endcase
    if (r.wen && r.rd != '0)
      arch_regs[r.rd] = r.data;
    pending.push_back(r);
  endtask

  task automatic expect_value(string field, rv_types_pkg::word_t exp, rv_types_pkg::word_t act);
    if (exp !== act) begin
      $display("FAILED %s %s at pc %h: expected %h, actual %h",
               test_name, field, head.pc, exp, act);
      test_errors++;
    end
  endtask

  task automatic close_test();
    $display("%s: %0d instructions, %0d mismatches, %s", test_name, test_count,
             test_errors, (test_errors == 0) ? "PASS" : "FAIL");
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    test_idx++;
    test_count  = 0;
    test_errors = 0;
    test_name   = $sformatf("test_%02d", test_idx);
    if (test_idx == NUM_TESTS) begin
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches", NUM_TESTS,
               NUM_TESTS - tests_failed, tests_failed, total_errors);
      finished <= 1'b1;
    end
  endtask

  task automatic score_retirement();
    if (pending.size() == 0) begin
      $display("Retirement at pc %h with no valid instruction in flight", retire_pc_i);
      total_errors++;
    end else begin
      head = pending.pop_front();
      expect_value("pc", head.pc, retire_pc_i);
      expect_value("wen", 32'(head.wen), 32'(retire_wen_i));
      if (head.wen) begin
        expect_value("rd", 32'(head.rd), 32'(retire_rd_i));
        expect_value("data", head.data, retire_data_i);
      end
      expect_value("redirect", 32'(head.redirect), 32'(redirect_i));
      if (head.redirect)
        expect_value("target", head.target, redirect_target_i);
      expect_value("mem_ren", 32'(head.ren), 32'(mem_ren_i));
      expect_value("mem_wen", 32'(head.store), 32'(mem_wen_i));
      if (head.ren || head.store) begin
        expect_value("mem_addr", head.addr, mem_addr_i);
        expect_value("byte_en", 32'(head.byte_en), 32'(mem_byte_en_i));
      end
      if (head.store)
        expect_value("mem_wdata", head.wdata, mem_wdata_i);
      test_count++;
      if (test_count == TEST_LEN)
        close_test();
    end
  endtask

  // Inputs and DUT outputs are both sampled before this edge's updates
  always @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `RV_NREGS; i++)
        arch_regs[i] = '0;
      pending.delete();
    end else begin
      if (instr_valid_i)
        predict(instr_i, pc_i);
      if (retire_valid_i)
        score_retirement();
    end
  end

endmodule

// File: test/rv_core_props.sv
// Protocol assertions for the datapath top, bound into rv_exec_core
// Covers reset clearing, the fixed two-cycle retire latency and strobe exclusion
`timescale 1ns/10ps

module rv_core_props (
  input logic clk,
  input logic reset_i,
  input logic instr_valid_i,
  input logic retire_valid_i,
  input logic retire_wen_i,
  input logic redirect_i,
  input logic mem_ren_i,
  input logic mem_wen_i
);

  logic any_strobe;

  assign any_strobe = retire_valid_i | retire_wen_i | redirect_i | mem_ren_i | mem_wen_i;

  // Strobes are low after every reset edge
  reset_clears: assert property (@(posedge clk) reset_i |=> !any_strobe)
    else $error("strobe high after a reset edge");

  // Decode was cleared too, so the first cycle out of reset stays quiet
  reset_exit_quiet: assert property (@(posedge clk) $fell(reset_i) |=> !any_strobe)
    else $error("strobe high in the first cycle after reset");

  fixed_latency: assert property (@(posedge clk) disable iff (reset_i)
      (!$past(reset_i, 1) && !$past(reset_i, 2)) |-> retire_valid_i == $past(instr_valid_i, 2))
    else $error("retire_valid does not follow instr_valid by two cycles");

  mem_excl: assert property (@(posedge clk) disable iff (reset_i) !(mem_ren_i && mem_wen_i))
    else $error("memory read and write strobes high together");

endmodule

// File: hw/rv_exec_core.sv
// Top of the RV32I integer datapath: decode, register file and execute
// Retire outputs trail each valid instruction by two cycles
`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_exec_core (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   instr_valid_i,
  input  rv_types_pkg::word_t    instr_i,
  input  rv_types_pkg::word_t    pc_i,
  output logic                   retire_valid_o,
  output rv_types_pkg::word_t    retire_pc_o,
  output rv_types_pkg::regidx_t  retire_rd_o,
  output logic                   retire_wen_o,
  output rv_types_pkg::word_t    retire_data_o,
  output logic                   redirect_o,
  output rv_types_pkg::word_t    redirect_target_o,
  output logic                   mem_ren_o,
  output logic                   mem_wen_o,
  output rv_types_pkg::word_t    mem_addr_o,
  output logic [`RV_NBYTES-1:0]  mem_byte_en_o,
  output rv_types_pkg::word_t    mem_wdata_o
);

  rv_types_pkg::regidx_t rs1, rs2, dx_rs1, dx_rs2, dx_rd;
  rv_types_pkg::word_t   rs1_data, rs2_data, dx_pc, dx_rs1_data, dx_rs2_data, dx_imm;
  rv_types_pkg::alu_op_t dx_alu_op;
  rv_types_pkg::a_sel_t  dx_a_sel;
  rv_types_pkg::w_sel_t  dx_w_sel;
  rv_types_pkg::branch_t dx_branch_type;
  rv_types_pkg::store_t  dx_store_type;
  logic                  dx_valid, dx_b_imm, dx_wen, dx_branch, dx_jump, dx_jalr;
  logic                  dx_ren, dx_store, rf_wr_en;

  // Retired writes land in the register file at the next edge
  assign rf_wr_en = retire_valid_o & retire_wen_o;

  rv_decode rv_decode_inst (
    .clk, .reset_i, .instr_valid_i, .instr_i, .pc_i,
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .rs1_o(rs1), .rs2_o(rs2),
    .dx_valid_o(dx_valid), .dx_pc_o(dx_pc), .dx_rs1_o(dx_rs1), .dx_rs2_o(dx_rs2),
    .dx_rd_o(dx_rd), .dx_rs1_data_o(dx_rs1_data), .dx_rs2_data_o(dx_rs2_data),
    .dx_imm_o(dx_imm), .dx_alu_op_o(dx_alu_op), .dx_a_sel_o(dx_a_sel),
    .dx_b_imm_o(dx_b_imm), .dx_w_sel_o(dx_w_sel), .dx_wen_o(dx_wen),
    .dx_branch_o(dx_branch), .dx_branch_type_o(dx_branch_type), .dx_jump_o(dx_jump),
    .dx_jalr_o(dx_jalr), .dx_ren_o(dx_ren), .dx_store_o(dx_store),
    .dx_store_type_o(dx_store_type)
  );

  rv_reg_file rv_reg_file_inst (
    .clk, .reset_i, .rs1_i(rs1), .rs2_i(rs2), .wr_en_i(rf_wr_en),
    .wr_rd_i(retire_rd_o), .wr_data_i(retire_data_o),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  rv_execute rv_execute_inst (
    .clk, .reset_i, .dx_valid_i(dx_valid), .dx_pc_i(dx_pc), .dx_rs1_i(dx_rs1),
    .dx_rs2_i(dx_rs2), .dx_rd_i(dx_rd), .dx_rs1_data_i(dx_rs1_data),
    .dx_rs2_data_i(dx_rs2_data), .dx_imm_i(dx_imm), .dx_alu_op_i(dx_alu_op),
    .dx_a_sel_i(dx_a_sel), .dx_b_imm_i(dx_b_imm), .dx_w_sel_i(dx_w_sel),
    .dx_wen_i(dx_wen), .dx_branch_i(dx_branch), .dx_branch_type_i(dx_branch_type),
    .dx_jump_i(dx_jump), .dx_jalr_i(dx_jalr), .dx_ren_i(dx_ren), .dx_store_i(dx_store),
    .dx_store_type_i(dx_store_type), .retire_valid_o, .retire_pc_o, .retire_rd_o,
    .retire_wen_o, .retire_data_o, .redirect_o, .redirect_target_o, .mem_ren_o,
    .mem_wen_o, .mem_addr_o, .mem_byte_en_o, .mem_wdata_o
  );

endmodule

// File: hw/rv_execute.sv
// Execute stage: forwarding, ALU, branch compare, jump targets and memory
// request, all registered into the retire outputs
`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_execute (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     dx_valid_i,
  input  rv_types_pkg::word_t      dx_pc_i,
  input  rv_types_pkg::regidx_t    dx_rs1_i,
  input  rv_types_pkg::regidx_t    dx_rs2_i,
  input  rv_types_pkg::regidx_t    dx_rd_i,
  input  rv_types_pkg::word_t      dx_rs1_data_i,
  input  rv_types_pkg::word_t      dx_rs2_data_i,
  input  rv_types_pkg::word_t      dx_imm_i,
  input  rv_types_pkg::alu_op_t    dx_alu_op_i,
  input  rv_types_pkg::a_sel_t     dx_a_sel_i,
  input  logic                     dx_b_imm_i,
  input  rv_types_pkg::w_sel_t     dx_w_sel_i,
  input  logic                     dx_wen_i,
  input  logic                     dx_branch_i,
  input  rv_types_pkg::branch_t    dx_branch_type_i,
  input  logic                     dx_jump_i,
  input  logic                     dx_jalr_i,
  input  logic                     dx_ren_i,
  input  logic                     dx_store_i,
  input  rv_types_pkg::store_t     dx_store_type_i,
  output logic                     retire_valid_o,
  output rv_types_pkg::word_t      retire_pc_o,
  output rv_types_pkg::regidx_t    retire_rd_o,
  output logic                     retire_wen_o,
  output rv_types_pkg::word_t      retire_data_o,
  output logic                     redirect_o,
  output rv_types_pkg::word_t      redirect_target_o,
  output logic                     mem_ren_o,
  output logic                     mem_wen_o,
  output rv_types_pkg::word_t      mem_addr_o,
  output logic [`RV_NBYTES-1:0]    mem_byte_en_o,
  output rv_types_pkg::word_t      mem_wdata_o
);

  rv_types_pkg::word_t   op_a, op_b, alu_a, alu_b, alu_res;
  rv_types_pkg::word_t   pc_imm, target, wb_data, st_data;
  logic                  fwd_ok, taken;
  logic [`RV_NBYTES-1:0] be_base;

  // Forward from retire when it writes a nonzero rd
  assign fwd_ok = retire_valid_o && retire_wen_o && (retire_rd_o != '0);
  assign op_a   = (fwd_ok && retire_rd_o == dx_rs1_i) ? retire_data_o : dx_rs1_data_i;
  assign op_b   = (fwd_ok && retire_rd_o == dx_rs2_i) ? retire_data_o : dx_rs2_data_i;

  assign alu_a = (dx_a_sel_i == rv_types_pkg::A_PC) ? dx_pc_i : op_a;
  assign alu_b = dx_b_imm_i ? dx_imm_i : op_b;

  always_comb begin
    case (dx_alu_op_i)
      rv_types_pkg::ALU_ADD:  alu_res = alu_a + alu_b;
      rv_types_pkg::ALU_SUB:  alu_res = alu_a - alu_b;
      rv_types_pkg::ALU_SLL:  alu_res = alu_a << alu_b[4:0];
      rv_types_pkg::ALU_SLT:  alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
      rv_types_pkg::ALU_SLTU: alu_res = {31'b0, alu_a < alu_b};
      rv_types_pkg::ALU_XOR:  alu_res = alu_a ^ alu_b;
      rv_types_pkg::ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
      rv_types_pkg::ALU_SRA:  alu_res = $signed(alu_a) >>> alu_b[4:0];
      rv_types_pkg::ALU_OR:   alu_res = alu_a | alu_b;
      rv_types_pkg::ALU_AND:  alu_res = alu_a & alu_b;
      default:                alu_res = '0;
    endcase
  end

  always_comb begin
    case (dx_branch_type_i)
      rv_types_pkg::BEQ:  taken = (op_a == op_b);
      rv_types_pkg::BNE:  taken = (op_a != op_b);
      rv_types_pkg::BLT:  taken = ($signed(op_a) < $signed(op_b));
      rv_types_pkg::BGE:  taken = ($signed(op_a) >= $signed(op_b));
      rv_types_pkg::BLTU: taken = (op_a < op_b);
      rv_types_pkg::BGEU: taken = (op_a >= op_b);
      default:            taken = 1'b0;
    endcase
  end

  // JALR uses the ALU sum rs1 + imm with bit 0 dropped
  assign pc_imm = dx_pc_i + dx_imm_i;
  assign target = dx_jalr_i ? {alu_res[31:1], 1'b0} : pc_imm;

  always_comb begin
    case (dx_w_sel_i)
      rv_types_pkg::W_LINK: wb_data = dx_pc_i + 32'd4;
      rv_types_pkg::W_IMM:  wb_data = dx_imm_i;
      default:              wb_data = alu_res;
    endcase
  end

  // Lane mask and replicated store data by access width
  always_comb begin
    case (dx_store_type_i)
      rv_types_pkg::SB: begin
        be_base = 4'b0001;
        st_data = {4{op_b[7:0]}};
      end
      rv_types_pkg::SH: begin
        be_base = 4'b0011;
        st_data = {2{op_b[15:0]}};
      end
      rv_types_pkg::SW: begin
        be_base = 4'b1111;
        st_data = op_b;
      end
      default: begin
        be_base = 4'b0000;
        st_data = op_b;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      retire_valid_o <= 1'b0;
      retire_wen_o   <= 1'b0;
      redirect_o     <= 1'b0;
      mem_ren_o      <= 1'b0;
      mem_wen_o      <= 1'b0;
    end else begin
      retire_valid_o <= dx_valid_i;
      retire_wen_o   <= dx_valid_i & dx_wen_i;
      redirect_o     <= dx_valid_i & (dx_jump_i | (dx_branch_i & taken));
      mem_ren_o      <= dx_valid_i & dx_ren_i;
      mem_wen_o      <= dx_valid_i & dx_store_i;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc_o       <= dx_pc_i;
    retire_rd_o       <= dx_rd_i;
    retire_data_o     <= wb_data;
    redirect_target_o <= target;
    mem_addr_o        <= alu_res;
    mem_byte_en_o     <= be_base << alu_res[1:0];
    mem_wdata_o       <= st_data;
  end

endmodule

// File: hw/rv_reg_file.sv
// Integer register file with two combinational read ports and one write port
// A write from retire is bypassed to a read of the same register in that cycle
`timescale 1ns/10ps
`include "rv_core_params.svh"

module rv_reg_file (
  input  logic                  clk,
  input  logic                  reset_i,
  input  rv_types_pkg::regidx_t rs1_i,
  input  rv_types_pkg::regidx_t rs2_i,
  input  logic                  wr_en_i,
  input  rv_types_pkg::regidx_t wr_rd_i,
  input  rv_types_pkg::word_t   wr_data_i,
  output rv_types_pkg::word_t   rs1_data_o,
  output rv_types_pkg::word_t   rs2_data_o
);

  rv_types_pkg::word_t regs [1:`RV_NREGS-1];

  function automatic rv_types_pkg::word_t read_port(rv_types_pkg::regidx_t idx);
    if (idx == '0)
      return '0;
    else if (wr_en_i && wr_rd_i == idx)
      return wr_data_i;
    else
      return regs[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < `RV_NREGS; i++)
        regs[i] <= '0;
    end else if (wr_en_i && wr_rd_i != '0) begin
      regs[wr_rd_i] <= wr_data_i;
    end
  end

endmodule

// File: hw/rv_decode.sv
// Decode stage: control unit and immediate generation for RV32I, with the
// dx_ register that carries fields and register read data into execute
`timescale 1ns/10ps

module rv_decode (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    instr_valid_i,
  input  rv_types_pkg::word_t     instr_i,
  input  rv_types_pkg::word_t     pc_i,
  input  rv_types_pkg::word_t     rs1_data_i,
  input  rv_types_pkg::word_t     rs2_data_i,
  output rv_types_pkg::regidx_t   rs1_o,
  output rv_types_pkg::regidx_t   rs2_o,
  output logic                    dx_valid_o,
  output rv_types_pkg::word_t     dx_pc_o,
  output rv_types_pkg::regidx_t   dx_rs1_o,
  output rv_types_pkg::regidx_t   dx_rs2_o,
  output rv_types_pkg::regidx_t   dx_rd_o,
  output rv_types_pkg::word_t     dx_rs1_data_o,
  output rv_types_pkg::word_t     dx_rs2_data_o,
  output rv_types_pkg::word_t     dx_imm_o,
  output rv_types_pkg::alu_op_t   dx_alu_op_o,
  output rv_types_pkg::a_sel_t    dx_a_sel_o,
  output logic                    dx_b_imm_o,
  output rv_types_pkg::w_sel_t    dx_w_sel_o,
  output logic                    dx_wen_o,
  output logic                    dx_branch_o,
  output rv_types_pkg::branch_t   dx_branch_type_o,
  output logic                    dx_jump_o,
  output logic                    dx_jalr_o,
  output logic                    dx_ren_o,
  output logic                    dx_store_o,
  output rv_types_pkg::store_t    dx_store_type_o
);

  rv_types_pkg::opcode_t opcode;
  logic [2:0]            funct3;
  rv_types_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  rv_types_pkg::alu_op_t alu_op;
  rv_types_pkg::a_sel_t  a_sel;
  rv_types_pkg::w_sel_t  w_sel;
  logic                  b_imm, wen, branch, jump, jalr, ren, store;

  assign opcode = rv_types_pkg::opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // Immediate formats; shift amounts ride in the I form
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Per-opcode control, unknown opcodes fall out as a no-op
  always_comb begin
    imm    = imm_i;
    a_sel  = rv_types_pkg::A_RS1;
    b_imm  = 1'b0;
    w_sel  = rv_types_pkg::W_ALU;
    wen    = 1'b0;
    branch = 1'b0;
    jump   = 1'b0;
    jalr   = 1'b0;
    ren    = 1'b0;
    store  = 1'b0;
    case (opcode)
      rv_types_pkg::LUI: begin
        imm   = imm_u;
        w_sel = rv_types_pkg::W_IMM;
        wen   = 1'b1;
      end
      rv_types_pkg::AUIPC: begin
        imm   = imm_u;
        a_sel = rv_types_pkg::A_PC;
        b_imm = 1'b1;
        wen   = 1'b1;
      end
      rv_types_pkg::JAL: begin
        imm   = imm_j;
        w_sel = rv_types_pkg::W_LINK;
        wen   = 1'b1;
        jump  = 1'b1;
      end
      rv_types_pkg::JALR: begin
        b_imm = 1'b1;
        w_sel = rv_types_pkg::W_LINK;
        wen   = 1'b1;
        jump  = 1'b1;
        jalr  = 1'b1;
      end
      rv_types_pkg::BRANCH: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      rv_types_pkg::LOAD: begin
        b_imm = 1'b1;
        ren   = 1'b1;
      end
      rv_types_pkg::STORE: begin
        imm   = imm_s;
        b_imm = 1'b1;
        store = 1'b1;
      end
      rv_types_pkg::IMMED: begin
        b_imm = 1'b1;
        wen   = 1'b1;
      end
      rv_types_pkg::REGREG: wen = 1'b1;
      default: ;
    endcase
  end

  // ALU op from funct3 and bit 30; everything outside OP and OP-IMM adds
  always_comb begin
    alu_op = rv_types_pkg::ALU_ADD;
    if (opcode == rv_types_pkg::REGREG || opcode == rv_types_pkg::IMMED) begin
      case (funct3)
        3'b000: alu_op = (opcode == rv_types_pkg::REGREG && instr_i[30]) ?
                         rv_types_pkg::ALU_SUB : rv_types_pkg::ALU_ADD;
        3'b001: alu_op = rv_types_pkg::ALU_SLL;
        3'b010: alu_op = rv_types_pkg::ALU_SLT;
        3'b011: alu_op = rv_types_pkg::ALU_SLTU;
        3'b100: alu_op = rv_types_pkg::ALU_XOR;
        3'b101: alu_op = instr_i[30] ? rv_types_pkg::ALU_SRA : rv_types_pkg::ALU_SRL;
        3'b110: alu_op = rv_types_pkg::ALU_OR;
        default: alu_op = rv_types_pkg::ALU_AND;
      endcase
    end
  end

  // Strobes, cleared on reset and on idle cycles
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dx_valid_o  <= 1'b0;
      dx_wen_o    <= 1'b0;
      dx_branch_o <= 1'b0;
      dx_jump_o   <= 1'b0;
      dx_ren_o    <= 1'b0;
      dx_store_o  <= 1'b0;
    end else begin
      dx_valid_o  <= instr_valid_i;
      dx_wen_o    <= instr_valid_i & wen;
      dx_branch_o <= instr_valid_i & branch;
      dx_jump_o   <= instr_valid_i & jump;
      dx_ren_o    <= instr_valid_i & ren;
      dx_store_o  <= instr_valid_i & store;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    dx_pc_o          <= pc_i;
    dx_rs1_o         <= rs1_o;
    dx_rs2_o         <= rs2_o;
    dx_rd_o          <= instr_i[11:7];
    dx_rs1_data_o    <= rs1_data_i;
    dx_rs2_data_o    <= rs2_data_i;
    dx_imm_o         <= imm;
    dx_alu_op_o      <= alu_op;
    dx_a_sel_o       <= a_sel;
    dx_b_imm_o       <= b_imm;
    dx_w_sel_o       <= w_sel;
    dx_jalr_o        <= jalr;
    dx_branch_type_o <= rv_types_pkg::branch_t'(funct3);
    dx_store_type_o  <= rv_types_pkg::store_t'({1'b0, funct3[1:0]});
  end

endmodule

// File: hw/rv_types_pkg.sv
// Shared types of the RV32I datapath: data and index vectors, opcodes and
// the control encodings passed from decode to execute
`include "rv_core_params.svh"

package rv_types_pkg;

  // Data, address and instruction word
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index
  typedef logic [`RV_REGW-1:0] regidx_t;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  // Branch conditions, same code as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Access width, low two bits of funct3 for loads and stores
  typedef enum logic [2:0] {
    SB = 3'b000,
    SH = 3'b001,
    SW = 3'b010
  } store_t;

  // First ALU operand source
  typedef enum logic [1:0] {
    A_RS1 = 2'd0,
    A_PC  = 2'd1
  } a_sel_t;

  // Writeback source
  typedef enum logic [1:0] {
    W_ALU  = 2'd0,
    W_LINK = 2'd1,
    W_IMM  = 2'd2
  } w_sel_t;

endpackage

// File: include/rv_core_params.svh
// Width and size constants for the RV32I integer datapath
// Included by the type package and by every block that sizes a vector
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data word, address and instruction width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NREGS 32

// Bits needed to name one register
`define RV_REGW 5

// Byte lanes in one data word
`define RV_NBYTES (`RV_XLEN / 8)

`endif
